// File: design/dma_pkg.sv
/* sprite dma walk constants
   counter size, work ram addressing, phase codes and the
   scrambled order in which the counter reaches work ram */
package dma_pkg;

    // dma counter, bit 10 is the done/idle flag
    localparam int dma_cnt_w = 11;

    // main work ram, 1024 bytes
    localparam int ram_aw = 10;

    // horizontal phase codes
    localparam logic [1:0] phase_step  = 2'b10;   // counter moves on
    localparam logic [1:0] phase_write = 2'b01;   // fetched byte goes to the lane

    // counter bit i lands on work ram address bit addr_perm[i]
    // the board wiring scrambles the order, so the sprite table in
    // work ram is not laid out linearly
    localparam int addr_perm [ram_aw] = '{
        2,  // bit 0
        6,  // bit 1
        3,  // bit 2
        4,  // bit 3
        7,  // bit 4
        8,  // bit 5
        9,  // bit 6
        5,  // bit 7
        0,  // bit 8, lane select low
        1   // bit 9, lane select high
    };

endpackage

// File: design/sprite_pkg.sv
/* object buffer layout
   four byte lanes per object entry, and the same entry
   seen as sprite fields */
package sprite_pkg;

    localparam int obj_aw = 8;                       // 256 objects
    localparam int lane_w [4] = '{8, 8, 8, 5};      // lane 3 keeps 5 bits only
    localparam int obj_w = 29;                       // sum of the lanes

    // raw view, one member per lane ram
    typedef struct packed {
        logic [lane_w[3]-1:0] lane3;
        logic [lane_w[2]-1:0] lane2;
        logic [lane_w[1]-1:0] lane1;
        logic [lane_w[0]-1:0] lane0;
    } obj_lanes_t;

    // attribute byte as it sits in lane 3
    typedef struct packed {
        logic       flip_y;
        logic       flip_x;
        logic [2:0] palette;
    } obj_attr_t;

    // decoded view, y in the lowest byte
    typedef struct packed {
        obj_attr_t  attr;
        logic [7:0] tile;
        logic [7:0] x;
        logic [7:0] y;
    } obj_fields_t;

    // same 29 bits, read either way
    typedef union packed {
        obj_lanes_t  lanes;
        obj_fields_t fields;
    } obj_entry_t;

endpackage

// File: design/obj_wr_if.sv
/* dma byte write path
   controller to object buffer, one lane byte per strobe */
`timescale 1ns/1ps

interface obj_wr_if;
    import sprite_pkg::*;

    logic [obj_aw-1:0] buf_addr;   // object index from counter 7:0
    logic [7:0]        wr_data;    // byte from work ram
    logic [1:0]        lane_sel;   // counter 9:8
    logic              wr_en;      // single cen cycle

    // controller side
    modport ctrl (
        output buf_addr, wr_data, lane_sel, wr_en
    );

    // object buffer side
    modport buff (
        input buf_addr, wr_data, lane_sel, wr_en
    );

endinterface

// File: design/obj_lane_ram.sv
/* one object lane, 256 entries
   single port, write and registered read on cen */
`timescale 1ns/1ps

module obj_lane_ram #(
    parameter int dw = 8
) (
    input  logic                         clk,
    input  logic                         cen,
    input  logic [sprite_pkg::obj_aw-1:0] addr,
    input  logic [dw-1:0]                data,
    input  logic                         we,
    output logic [dw-1:0]                q
);
    import sprite_pkg::*;

    logic [dw-1:0] mem [2**obj_aw];

    always_ff @(posedge clk) begin
        if (cen) begin
            if (we) begin
                mem[addr] <= data;
            end
            q <= mem[addr];   // old data on a write cycle
        end
    end

endmodule

// File: design/work_ram.sv
/* main cpu work ram, 1 kbyte
   cpu byte writes, plus a registered read for the sprite dma */
`timescale 1ns/1ps

module work_ram (
    input  logic                       clk,
    input  logic                       cen,
    input  logic                       cpu_we,
    input  logic [dma_pkg::ram_aw-1:0] cpu_addr,
    input  logic [7:0]                 cpu_data,
    input  logic                       dma_cs,
    input  logic [dma_pkg::ram_aw-1:0] dma_addr,
    output logic [7:0]                 dma_data
);
    import dma_pkg::*;

    logic [7:0] mem [2**ram_aw];   // sprite table lives in here too
    logic       cpu_wr_ok;

    // cpu is locked out while dma owns the ram
    assign cpu_wr_ok = cpu_we & ~dma_cs;

    always_ff @(posedge clk) begin
        if (cen) begin
            if (cpu_wr_ok) begin
                mem[cpu_addr] <= cpu_data;
            end
            if (dma_cs) begin
                dma_data <= mem[dma_addr];   // ready one cen later
            end
        end
    end

endmodule

// File: design/sprite_dma_ctrl.sv
/* sprite dma controller
   walks the work ram at vblank while the cpu bus is granted,
   scrambling the address and strobing one lane write per byte */
`timescale 1ns/1ps

module sprite_dma_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,
    input  logic                       vblank,
    input  logic [1:0]                 hphase,
    input  logic                       busak_n,
    output logic                       busrq_n,
    output logic                       dma_done,
    output logic [dma_pkg::ram_aw-1:0] dma_addr,
    output logic                       dma_cs,
    obj_wr_if.ctrl                     wr,
    input  logic [7:0]                 dma_data
);
    import dma_pkg::*;

    logic [dma_cnt_w-1:0] cnt;        // walk position, msb set = idle
    logic                 vblank_l;   // vblank at last cen
    logic                 vb_rise;
    logic                 active;     // granted and not done yet

    assign vb_rise  = vblank & ~vblank_l;
    assign active   = ~busak_n & ~cnt[dma_cnt_w-1];
    assign dma_done = cnt[dma_cnt_w-1];

    // counter only moves with the grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank_l <= 1'b0;
            cnt      <= {1'b1, {(dma_cnt_w-1){1'b0}}};   // idle, done high
        end else if (cen) begin
            vblank_l <= vblank;
            if (vb_rise) begin
                cnt <= '0;                                 // new frame, start over
            end else if (active && hphase == phase_step) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // bus request held from vblank until the walk ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busrq_n <= 1'b1;
        end else if (cen) begin
            if (vb_rise) begin
                busrq_n <= 1'b0;
            end else if (cnt[dma_cnt_w-1]) begin
                busrq_n <= 1'b1;   // done, hand the bus back
            end
        end
    end

    // scrambled work ram address
    always_comb begin
        dma_addr = '0;
        for (int i = 0; i < ram_aw; i++) begin
            dma_addr[addr_perm[i]] = cnt[i];
        end
    end

    // fetch half of the phase, phases 0 and 1
    assign dma_cs = active & ~hphase[1];

    // byte fetched at phase 0 is written at phase 1
    assign wr.buf_addr = cnt[7:0];
    assign wr.lane_sel = cnt[9:8];
    assign wr.wr_data  = dma_data;
    assign wr.wr_en    = cen & dma_cs & (hphase == phase_write);

endmodule

// File: design/obj_buffer.sv
/* object buffer
   four lane rams filled by the dma, read back by object index
   and packed into one entry */
`timescale 1ns/1ps

module obj_buffer (
    input  logic                          clk,
    input  logic                          cen,
    obj_wr_if.buff                        wr,
    input  logic [sprite_pkg::obj_aw-1:0] obj_index,
    output sprite_pkg::obj_entry_t        entry
);
    import sprite_pkg::*;

    logic [3:0]        lane_we;    // one hot from lane_sel
    logic [obj_aw-1:0] lane_addr;  // shared by all four lanes
    logic [obj_w-1:0]  rd_word;    // lane outputs side by side

    // lane decode
    always_comb begin
        lane_we = '0;
        lane_we[wr.lane_sel] = wr.wr_en;
    end

    // dma writes win, readback otherwise
    assign lane_addr = wr.wr_en ? wr.buf_addr : obj_index;

    obj_lane_ram #(.dw(lane_w[0])) u_lane0 (
        .clk  (clk),
        .cen  (cen),
        .addr (lane_addr),
        .data (wr.wr_data),
        .we   (lane_we[0]),
        .q    (rd_word[7:0])
    );

    obj_lane_ram #(.dw(lane_w[1])) u_lane1 (
        .clk  (clk),
        .cen  (cen),
        .addr (lane_addr),
        .data (wr.wr_data),
        .we   (lane_we[1]),
        .q    (rd_word[15:8])
    );

    obj_lane_ram #(.dw(lane_w[2])) u_lane2 (
        .clk  (clk),
        .cen  (cen),
        .addr (lane_addr),
        .data (wr.wr_data),
        .we   (lane_we[2]),
        .q    (rd_word[23:16])
    );

    // attribute lane, top 3 bits of the byte dropped
    obj_lane_ram #(.dw(lane_w[3])) u_lane3 (
        .clk  (clk),
        .cen  (cen),
        .addr (lane_addr),
        .data (wr.wr_data[lane_w[3]-1:0]),
        .we   (lane_we[3]),
        .q    (rd_word[28:24])
    );

    // raw lanes into the union
    assign entry.lanes = rd_word;

endmodule

// File: design/sprite_dma_top.sv
/* sprite dma top
   controller, work ram and object buffer, with the object
   entry decoded onto sprite field outputs */
`timescale 1ns/1ps

module sprite_dma_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cen,
    input  logic                          vblank,
    input  logic [1:0]                    hphase,
    input  logic                          busak_n,
    input  logic                          cpu_we,
    input  logic [dma_pkg::ram_aw-1:0]    cpu_addr,
    input  logic [7:0]                    cpu_data,
    input  logic [sprite_pkg::obj_aw-1:0] obj_index,
    output logic                          busrq_n,
    output logic                          dma_done,
    output logic [7:0]                    obj_y,
    output logic [7:0]                    obj_x,
    output logic [7:0]                    obj_tile,
    output logic [2:0]                    obj_palette,
    output logic                          obj_flip_x,
    output logic                          obj_flip_y
);
    import dma_pkg::*;
    import sprite_pkg::*;

    logic [ram_aw-1:0] dma_addr;
    logic              dma_cs;
    logic [7:0]        dma_data;
    obj_entry_t        entry;     // lanes in, fields out

    obj_wr_if u_obj_wr ();

    sprite_dma_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .vblank   (vblank),
        .hphase   (hphase),
        .busak_n  (busak_n),
        .busrq_n  (busrq_n),
        .dma_done (dma_done),
        .dma_addr (dma_addr),
        .dma_cs   (dma_cs),
        .wr       (u_obj_wr.ctrl),
        .dma_data (dma_data)
    );

    // cpu side of the board stands in as a plain byte port
    work_ram u_work_ram (
        .clk      (clk),
        .cen      (cen),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .dma_cs   (dma_cs),
        .dma_addr (dma_addr),
        .dma_data (dma_data)
    );

    obj_buffer u_obj_buffer (
        .clk       (clk),
        .cen       (cen),
        .wr        (u_obj_wr.buff),
        .obj_index (obj_index),
        .entry     (entry)
    );

    // sprite fields
    assign obj_y       = entry.fields.y;
    assign obj_x       = entry.fields.x;
    assign obj_tile    = entry.fields.tile;
    assign obj_palette = entry.fields.attr.palette;
    assign obj_flip_x  = entry.fields.attr.flip_x;
    assign obj_flip_y  = entry.fields.attr.flip_y;

endmodule

// File: testbench/tb_sprite_dma.sv
/* sprite dma testbench
   fills work ram from the cpu port, runs dma walks with and without
   grant drops, and checks object readback against a permutation model */
`timescale 1ns/1ps

module tb_sprite_dma;

    localparam int seed     = 24;
    localparam int n_idx    = 8;
    localparam int n_walks  = 4;
    localparam real cen_density = 0.75;   // cen high on 3 of 4 lcg draws
    localparam real watchdog_ns = 4.0 * 1024.0 * 4.0 * 20.0 * n_walks / cen_density;

    // counter bit i to work ram address bit as wired on the board
    localparam int perm_tab [10] = '{2, 6, 3, 4, 7, 8, 9, 5, 0, 1};

    // object indices checked after every walk
    localparam int check_idx [n_idx] = '{0, 1, 37, 100, 128, 199, 254, 255};

    // one row per walk with the grant drop point in phase periods,
    // the drop length in clocks (0 for none) and the cpu byte updates
    // made before the walk
    // the row 2 drop lands just ahead of counter value 455, a byte the cpu rewrote
    localparam int drop_at   [n_walks] = '{0, 300, 455, 1000};
    localparam int drop_span [n_walks] = '{0, 150, 41, 500};
    localparam int cpu_upd   [n_walks] = '{0, 0, 6, 4};

    logic       clk;
    logic       rst_n;
    logic       cen;
    logic       vblank;
    logic [1:0] hphase;
    logic       busak_n;
    logic       cpu_we;
    logic [9:0] cpu_addr;
    logic [7:0] cpu_data;
    logic [7:0] obj_index;
    logic       busrq_n;
    logic       dma_done;
    logic [7:0] obj_y;
    logic [7:0] obj_x;
    logic [7:0] obj_tile;
    logic [2:0] obj_palette;
    logic       obj_flip_x;
    logic       obj_flip_y;

    logic [7:0]  mirror [1024];   // what the work ram should hold
    logic [28:0] old_exp [n_idx];
    logic [28:0] first_rd;
    logic [28:0] second_rd;
    logic [31:0] cen_state  = seed;
    logic [31:0] data_state = seed;

    sprite_dma_top u_sprite_dma_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen         (cen),
        .vblank      (vblank),
        .hphase      (hphase),
        .busak_n     (busak_n),
        .cpu_we      (cpu_we),
        .cpu_addr    (cpu_addr),
        .cpu_data    (cpu_data),
        .obj_index   (obj_index),
        .busrq_n     (busrq_n),
        .dma_done    (dma_done),
        .obj_y       (obj_y),
        .obj_x       (obj_x),
        .obj_tile    (obj_tile),
        .obj_palette (obj_palette),
        .obj_flip_x  (obj_flip_x),
        .obj_flip_y  (obj_flip_y)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // counter value to scrambled work ram address
    function automatic int scramble(input int c);
        int a;
        a = 0;
        for (int i = 0; i < 10; i++) begin
            a = a | (((c >> i) & 1) << perm_tab[i]);
        end
        return a;
    endfunction

    // lane k of entry j comes from counter value k*256 + j
    function automatic logic [28:0] expected_entry(input int idx);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = mirror[scramble(idx)];
        b1 = mirror[scramble(256 + idx)];
        b2 = mirror[scramble(512 + idx)];
        b3 = mirror[scramble(768 + idx)];
        return {b3[4:0], b2, b1, b0};   // lane 3 keeps 5 bits
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int idx,
                               input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("Fail time=%0t signal=%s index=%0d got=%0h expected=%0h",
                     $time, name, idx, got, exp);
            abort_run();
        end
    endtask

    // returns right after a rising edge that saw cen high at phase ph
    task automatic wait_cen_phase(input logic [1:0] ph);
        @(posedge clk);
        while (!(cen && hphase == ph)) @(posedge clk);
    endtask

    task automatic cpu_write(input int addr, input logic [7:0] data);
        cpu_we   <= 1'b1;
        cpu_addr <= addr[9:0];
        cpu_data <= data;
        @(posedge clk);
        while (!cen) @(posedge clk);   // taken on this edge
    endtask

    task automatic fill_ram();
        for (int a = 0; a < 1024; a++) begin
            data_state = lcg_next(data_state);
            mirror[a]  = data_state[23:16];
            cpu_write(a, data_state[23:16]);
        end
        cpu_we <= 1'b0;
    endtask

    // registered lane read valid after the first cen edge
    task automatic read_entry(input int idx, output logic [28:0] word);
        obj_index <= idx[7:0];
        @(posedge clk);
        while (!cen) @(posedge clk);
        @(negedge clk);                // sample mid cycle
        word = {obj_flip_y, obj_flip_x, obj_palette, obj_tile, obj_x, obj_y};
        @(posedge clk);
    endtask

    task automatic check_entry(input int idx, input logic [28:0] exp);
        logic [28:0] got;
        read_entry(idx, got);
        check_value("obj_y", idx, got[7:0], exp[7:0]);
        check_value("obj_x", idx, got[15:8], exp[15:8]);
        check_value("obj_tile", idx, got[23:16], exp[23:16]);
        check_value("obj_palette", idx, {5'd0, got[26:24]}, {5'd0, exp[26:24]});
        check_value("obj_flip_x", idx, {7'd0, got[27]}, {7'd0, exp[27]});
        check_value("obj_flip_y", idx, {7'd0, got[28]}, {7'd0, exp[28]});
    endtask

    // vblank with immediate grant and optional grant drop then wait for done
    task automatic run_walk(input int row);
        wait_cen_phase(2'd2);          // vblank seen at phase 3 so the walk opens at 0
        vblank  <= 1'b1;
        busak_n <= 1'b0;
        @(posedge clk);
        while (busrq_n !== 1'b0) @(posedge clk);
        check_value("dma_done", row, {7'd0, dma_done}, 8'd0);
        if (drop_span[row] > 0) begin
            repeat (drop_at[row]) wait_cen_phase(2'd3);
            busak_n <= 1'b1;           // drop on a period boundary
            repeat (drop_span[row]) @(posedge clk);
            check_value("dma_done", row, {7'd0, dma_done}, 8'd0);   // frozen
            check_value("busrq_n", row, {7'd0, busrq_n}, 8'd0);
            wait_cen_phase(2'd3);
            busak_n <= 1'b0;           // resume at phase 0
        end
        @(posedge clk);
        while (dma_done !== 1'b1) @(posedge clk);
        check_value("busrq_n", row, {7'd0, busrq_n}, 8'd0);   // released one cen later
        @(posedge clk);
        while (busrq_n !== 1'b1) @(posedge clk);
        busak_n <= 1'b1;
        vblank  <= 1'b0;
    endtask

    // cpu touches bytes that feed checked entries with one lane each
    task automatic cpu_updates(input int row);
        int idx;
        int addr;
        for (int w = 0; w < cpu_upd[row]; w++) begin
            idx  = check_idx[(row + 3 * w) % n_idx];
            addr = scramble((w % 4) * 256 + idx);
            data_state = lcg_next(data_state);
            mirror[addr] = data_state[23:16];
            cpu_write(addr, data_state[23:16]);
        end
        cpu_we <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // cen from the lcg and hphase steps once per cen cycle
    always @(posedge clk) begin
        if (cen) begin
            hphase <= hphase + 2'd1;
        end
        cen_state = lcg_next(cen_state);
        cen <= (cen_state[31:30] != 2'b00);
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the test sequence finished");
        abort_run();
    end

    initial begin
        rst_n     = 1'b0;
        cen       = 1'b0;
        vblank    = 1'b0;
        hphase    = 2'd0;
        busak_n   = 1'b1;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_data  = '0;
        obj_index = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // idle after reset with no dma writes while the ram fills
        check_value("busrq_n", 0, {7'd0, busrq_n}, 8'd1);
        check_value("dma_done", 0, {7'd0, dma_done}, 8'd1);
        read_entry(check_idx[2], first_rd);
        fill_ram();
        read_entry(check_idx[2], second_rd);
        assert (first_rd === second_rd) else begin
            $display("object entry changed while the dma was idle");
            abort_run();
        end

        for (int r = 0; r < n_walks; r++) begin
            for (int i = 0; i < n_idx; i++) begin
                old_exp[i] = expected_entry(check_idx[i]);
            end
            cpu_updates(r);
            if (cpu_upd[r] > 0) begin
                // buffer keeps the old walk until the next vblank
                for (int i = 0; i < n_idx; i++) begin
                    check_entry(check_idx[i], old_exp[i]);
                end
            end
            run_walk(r);
            for (int i = 0; i < n_idx; i++) begin
                check_entry(check_idx[i], expected_entry(check_idx[i]));
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: compile.f
design/dma_pkg.sv
design/sprite_pkg.sv
design/obj_wr_if.sv
design/obj_lane_ram.sv
design/work_ram.sv
design/sprite_dma_ctrl.sv
design/obj_buffer.sv
design/sprite_dma_top.sv
testbench/tb_sprite_dma.sv

// File: Bender.yml
package:
  name: sprite_dma

sources:
  # packages first, then the interface and the modules bottom up
  - files:
      - design/dma_pkg.sv
      - design/sprite_pkg.sv
      - design/obj_wr_if.sv
      - design/obj_lane_ram.sv
      - design/work_ram.sv
      - design/sprite_dma_ctrl.sv
      - design/obj_buffer.sv
      - design/sprite_dma_top.sv

  # testbench, top module tb_sprite_dma
  - target: test
    files:
      - testbench/tb_sprite_dma.sv
